// File: tb.f
hdl/fpaPkg.sv
hdl/fpaBusRegs.sv
hdl/fpaSequencer.sv
hdl/fixToFloat.sv
hdl/fpMultiplier.sv
hdl/fpAccel.sv
tb/fpAccel_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator and run the testbench from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module fpAccel_tb -Mdir obj_dir -f tb.f \
	&& output="$(./obj_dir/VfpAccel_tb)" \
	&& echo "$output" \
	&& echo "$output" | grep -qx "TEST OK" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: tb/fpAccel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fpAccel_tb;

	localparam logic [23:0] BaseAddr = 24'hFEA200;
	// About 40 commands of at most 90 cycles, each with four 12-byte transfers
	// at up to 3 cycles a byte, then doubled for margin
	localparam int TimeoutCycles = 20000;

	logic        clk = 1'b0;
	logic        rst;
	logic        vda;
	logic        rw;
	logic [23:0] ad;
	logic [7:0]  writeData;
	logic [7:0]  readData;
	logic        rdy;

	int          errorCount = 0;
	int          checkCount = 0;
	int          cycleCount = 0;
	// Cycles the last bus write spent waiting for rdy
	int          lastWriteStalls;
	logic [31:0] rngState = 32'hddbd8ee0;

	fpAccel #(
		.BaseAddr(BaseAddr)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.vda(vda),
		.rw(rw),
		.ad(ad),
		.writeData(writeData),
		.readData(readData),
		.rdy(rdy)
	);

	always #20 clk = ~clk;

	// Watchdog
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			$display("Timeout: the tests did not finish within %0d clock cycles", TimeoutCycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ====================
	// Random numbers
	// ====================

	// Xorshift32 step
	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	// Normalized value, exponent kept near the bias so products stay in range
	function automatic fpaPkg::fpVal_t makeNormalFloat();
		fpaPkg::fpVal_t v;
		logic [31:0]    r;
		logic [95:0]    m;
		r = nextRandom();
		m = {nextRandom(), nextRandom(), nextRandom()};
		v.sign = r[31];
		v.exponent = 15'(fpaPkg::ExpBias - 1000 + int'(r[15:0] % 16'd2001));
		v.mantissa = {1'b1, m[78:0]};
		return v;
	endfunction

	// Signed integer of random width, never the most negative value
	function automatic logic [79:0] makeSignedInt();
		logic [95:0] bits;
		logic [79:0] mag;
		int          shift;
		bits = {nextRandom(), nextRandom(), nextRandom()};
		shift = int'(bits[95:89]) % 79;
		mag = {1'b0, bits[78:0]} >> shift;
		if (bits[88]) begin
			return 80'd0 - mag;
		end
		return mag;
	endfunction

	// ====================
	// Reference model
	// ====================

	// Exact conversion, leading one found by scanning
	function automatic fpaPkg::fpVal_t convertInt(input logic [79:0] x);
		fpaPkg::fpVal_t v;
		logic [79:0]    mag;
		int             top;
		int             i;
		v = '0;
		v.sign = x[79];
		mag = x[79] ? (80'd0 - x) : x;
		top = -1;
		for (i = 0; i < 80; i++) begin
			if (mag[i]) begin
				top = i;
			end
		end
		// Zero stays all zero
		if (top >= 0) begin
			v.exponent = 15'(fpaPkg::ExpBias + top);
			v.mantissa = mag << (79 - top);
		end
		return v;
	endfunction

	// Full 160-bit product, then one normalizing step and truncation
	function automatic fpaPkg::fpVal_t multiplyFloats(input fpaPkg::fpVal_t a,
			input fpaPkg::fpVal_t b);
		fpaPkg::fpVal_t v;
		logic [159:0]   p;
		logic [14:0]    e;
		v = '0;
		if (a.exponent != 15'd0 && b.exponent != 15'd0) begin
			p = {80'd0, a.mantissa} * {80'd0, b.mantissa};
			e = 15'(int'(a.exponent) + int'(b.exponent) - fpaPkg::ExpBias);
			v.sign = a.sign ^ b.sign;
			if (p[159]) begin
				v.mantissa = p[159:80];
				v.exponent = e + 15'd1;
			end else begin
				v.mantissa = p[158:79];
				v.exponent = e;
			end
		end
		return v;
	endfunction

	task automatic compareValue(input string what, input logic [95:0] got,
			input logic [95:0] expected);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			$display("ERROR at %0t ns: %s read %h, expected %h", $time, what, got, expected);
		end
	endtask

	// ====================
	// Bus tasks
	// ====================

	// Request held until rdy, sampled at the falling edge where it is settled
	task automatic busWrite(input logic [7:0] offset, input logic [7:0] data);
		@(posedge clk);
		vda <= 1'b1;
		rw <= 1'b0;
		ad <= BaseAddr + 24'(offset);
		writeData <= data;
		lastWriteStalls = 0;
		@(negedge clk);
		while (!rdy) begin
			lastWriteStalls++;
			@(negedge clk);
		end
		// Write lands on this edge
		@(posedge clk);
		vda <= 1'b0;
		rw <= 1'b1;
	endtask

	task automatic busRead(input logic [7:0] offset, output logic [7:0] data);
		@(posedge clk);
		vda <= 1'b1;
		rw <= 1'b1;
		ad <= BaseAddr + 24'(offset);
		@(negedge clk);
		// Reads are never held off
		if (!rdy) begin
			errorCount++;
			$display("Bus read of offset %h was stalled with rdy low at %0t ns", offset, $time);
		end
		data = readData;
		@(posedge clk);
		vda <= 1'b0;
	endtask

	// Little-endian, byte i at offset base+i
	task automatic loadFac(input logic [7:0] base, input logic [95:0] value);
		int i;
		for (i = 0; i < 12; i++) begin
			busWrite(base + 8'(i), value[8*i +: 8]);
		end
	endtask

	task automatic readFac(input logic [7:0] base, output logic [95:0] value);
		int         i;
		logic [7:0] b;
		value = '0;
		for (i = 0; i < 12; i++) begin
			busRead(base + 8'(i), b);
			value[8*i +: 8] = b;
		end
	endtask

	// Command write, then poll the status until busy clears
	task automatic runCmd(input logic [7:0] op, output int busyPolls);
		logic [7:0] status;
		busWrite(fpaPkg::RegCmd, op);
		busyPolls = 0;
		busRead(fpaPkg::RegCmd, status);
		while (status[7]) begin
			busyPolls++;
			busRead(fpaPkg::RegCmd, status);
		end
		checkCount++;
		if (status !== 8'h00) begin
			errorCount++;
			$display("ERROR at %0t ns: idle status read %h, expected 00", $time, status);
		end
	endtask

	// ====================
	// Directed tests
	// ====================

	task automatic registerAccess();
		logic [95:0] got;
		logic [95:0] v1;
		logic [95:0] v2;
		logic [7:0]  status;
		readFac(fpaPkg::RegFac1Base, got);
		compareValue("FAC1 after reset", got, '0);
		readFac(fpaPkg::RegFac2Base, got);
		compareValue("FAC2 after reset", got, '0);
		busRead(fpaPkg::RegCmd, status);
		compareValue("Status after reset", {88'd0, status}, '0);
		// Arbitrary bytes, no format implied
		v1 = {nextRandom(), nextRandom(), nextRandom()};
		v2 = {nextRandom(), nextRandom(), nextRandom()};
		loadFac(fpaPkg::RegFac1Base, v1);
		loadFac(fpaPkg::RegFac2Base, v2);
		readFac(fpaPkg::RegFac1Base, got);
		compareValue("FAC1 readback", got, v1);
		readFac(fpaPkg::RegFac2Base, got);
		compareValue("FAC2 readback", got, v2);
	endtask

	task automatic swapAccumulators();
		logic [95:0] got;
		logic [95:0] v1;
		logic [95:0] v2;
		int          polls;
		v1 = makeNormalFloat();
		v2 = makeNormalFloat();
		loadFac(fpaPkg::RegFac1Base, v1);
		loadFac(fpaPkg::RegFac2Base, v2);
		runCmd(fpaPkg::OpSwap, polls);
		readFac(fpaPkg::RegFac1Base, got);
		compareValue("FAC1 after SWAP", got, v2);
		readFac(fpaPkg::RegFac2Base, got);
		compareValue("FAC2 after SWAP", got, v1);
	endtask

	task automatic convertIntegers();
		logic [79:0] inputs[$];
		logic [95:0] got;
		logic [31:0] r;
		int          polls;
		int          i;
		inputs.push_back(80'h04D20000);
		inputs.push_back(80'd1);
		// Minus one
		inputs.push_back({80{1'b1}});
		inputs.push_back(80'd0);
		for (i = 0; i < 10; i++) begin
			inputs.push_back(makeSignedInt());
		end
		foreach (inputs[k]) begin
			// Sign and exponent bits of FAC1 must not matter
			r = nextRandom();
			loadFac(fpaPkg::RegFac1Base, {r[15:0], inputs[k]});
			runCmd(fpaPkg::OpFix2Flt, polls);
			readFac(fpaPkg::RegFac1Base, got);
			compareValue($sformatf("FIX2FLT of %h", inputs[k]), got, convertInt(inputs[k]));
		end
	endtask

	task automatic multiplyOperands();
		fpaPkg::fpVal_t aOps[$];
		fpaPkg::fpVal_t bOps[$];
		fpaPkg::fpVal_t x;
		logic [95:0]    got;
		int             polls;
		int             i;
		for (i = 0; i < 10; i++) begin
			aOps.push_back(makeNormalFloat());
			bOps.push_back(makeNormalFloat());
		end
		// All-ones mantissas give a product just under 4, top bit set
		x = makeNormalFloat();
		x.mantissa = '1;
		aOps.push_back(x);
		x = makeNormalFloat();
		x.mantissa = '1;
		bOps.push_back(x);
		// Mantissas of exactly one keep the top bit clear
		x = makeNormalFloat();
		x.mantissa = {1'b1, 79'd0};
		aOps.push_back(x);
		x = makeNormalFloat();
		x.mantissa = {1'b1, 79'd0};
		bOps.push_back(x);
		// Zero exponent in FAC1
		x = makeNormalFloat();
		x.exponent = '0;
		aOps.push_back(x);
		bOps.push_back(makeNormalFloat());
		foreach (aOps[k]) begin
			loadFac(fpaPkg::RegFac1Base, aOps[k]);
			loadFac(fpaPkg::RegFac2Base, bOps[k]);
			runCmd(fpaPkg::OpMul, polls);
			readFac(fpaPkg::RegFac1Base, got);
			compareValue($sformatf("MUL product %0d", k), got, multiplyFloats(aOps[k], bOps[k]));
			readFac(fpaPkg::RegFac2Base, got);
			compareValue($sformatf("FAC2 after MUL %0d", k), got, bOps[k]);
		end
	endtask

	task automatic writeWhileBusy();
		fpaPkg::fpVal_t a;
		fpaPkg::fpVal_t b;
		logic [95:0]    expected;
		logic [95:0]    got;
		logic [31:0]    r;
		logic [7:0]     status;
		a = makeNormalFloat();
		b = makeNormalFloat();
		r = nextRandom();
		loadFac(fpaPkg::RegFac1Base, a);
		loadFac(fpaPkg::RegFac2Base, b);
		busWrite(fpaPkg::RegCmd, fpaPkg::OpMul);
		// Byte 5 of FAC1 issued right behind the command
		busWrite(fpaPkg::RegFac1Base + 8'd5, r[7:0]);
		checkCount++;
		if (lastWriteStalls < 80) begin
			errorCount++;
			$display("ERROR at %0t ns: FAC write during MUL waited %0d cycles, expected at least 80",
				$time, lastWriteStalls);
		end
		busRead(fpaPkg::RegCmd, status);
		compareValue("Status after late write", {88'd0, status}, '0);
		expected = multiplyFloats(a, b);
		expected[47:40] = r[7:0];
		readFac(fpaPkg::RegFac1Base, got);
		compareValue("MUL product with late byte", got, expected);
	endtask

	task automatic unknownOpcode();
		logic [95:0] v1;
		logic [95:0] v2;
		logic [95:0] got;
		int          polls;
		v1 = {nextRandom(), nextRandom(), nextRandom()};
		v2 = {nextRandom(), nextRandom(), nextRandom()};
		loadFac(fpaPkg::RegFac1Base, v1);
		loadFac(fpaPkg::RegFac2Base, v2);
		runCmd(8'h00, polls);
		if (polls != 0) begin
			errorCount++;
			$display("Status showed busy after unknown opcode 00 at %0t ns", $time);
		end
		readFac(fpaPkg::RegFac1Base, got);
		compareValue("FAC1 after unknown opcode", got, v1);
		readFac(fpaPkg::RegFac2Base, got);
		compareValue("FAC2 after unknown opcode", got, v2);
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		rst = 1'b1;
		vda = 1'b0;
		rw = 1'b1;
		ad = '0;
		writeData = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		registerAccess();
		swapAccumulators();
		convertIntegers();
		multiplyOperands();
		writeWhileBusy();
		unknownOpcode();
		$display("Checks: %0d, errors: %0d, cycles: %0d", checkCount, errorCount, cycleCount);
		if (errorCount == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/fpAccel.sv
`timescale 1ns/1ps
`default_nettype none

module fpAccel #(
	// Bus address of register offset zero
	parameter logic [23:0] BaseAddr = 24'hFEA200
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        vda,
	input  logic        rw,
	input  logic [23:0] ad,
	input  logic [7:0]  writeData,
	output logic [7:0]  readData,
	output logic        rdy
);

	// Offsets 00h to 1Bh
	localparam logic [23:0] WindowSize = 24'h00001C;

	logic            inWindow;
	logic [23:0]     offset;
	fpaPkg::busReq_t req;
	logic            cmdValid;
	fpaPkg::fpaOp_t  cmdOp;
	logic            busy;
	fpaPkg::fpVal_t  fac1;
	fpaPkg::fpVal_t  fac2;
	logic            loadFac1;
	logic            loadFac2;
	fpaPkg::fpVal_t  newFac1;
	fpaPkg::fpVal_t  newFac2;
	logic            fixStart;
	logic            fixDone;
	fpaPkg::fpVal_t  fixResult;
	logic            mulStart;
	logic            mulDone;
	fpaPkg::fpVal_t  mulResult;

	// ====================
	// Window decode
	// ====================

	// Wraps to a large value below the base, so one compare covers both ends
	assign offset = ad - BaseAddr;
	assign inWindow = (offset < WindowSize);
	assign req = '{vda: vda, rw: rw, addr: offset[7:0], writeData: writeData};

	fpaBusRegs u_busRegs (
		.clk(clk),
		.rst(rst),
		.req(req),
		.inWindow(inWindow),
		.busy(busy),
		.loadFac1(loadFac1),
		.loadFac2(loadFac2),
		.newFac1(newFac1),
		.newFac2(newFac2),
		.readData(readData),
		.rdy(rdy),
		.cmdValid(cmdValid),
		.cmdOp(cmdOp),
		.fac1(fac1),
		.fac2(fac2)
	);

	fpaSequencer u_sequencer (
		.clk(clk),
		.rst(rst),
		.cmdValid(cmdValid),
		.cmdOp(cmdOp),
		.fac1(fac1),
		.fac2(fac2),
		.fixDone(fixDone),
		.fixResult(fixResult),
		.mulDone(mulDone),
		.mulResult(mulResult),
		.busy(busy),
		.fixStart(fixStart),
		.mulStart(mulStart),
		.loadFac1(loadFac1),
		.loadFac2(loadFac2),
		.newFac1(newFac1),
		.newFac2(newFac2)
	);

	// Integer sits in the low 80 bits of FAC1
	fixToFloat u_fixToFloat (
		.clk(clk),
		.rst(rst),
		.start(fixStart),
		.intIn(fac1.mantissa),
		.done(fixDone),
		.result(fixResult)
	);

	fpMultiplier u_fpMultiplier (
		.clk(clk),
		.rst(rst),
		.start(mulStart),
		.a(fac1),
		.b(fac2),
		.done(mulDone),
		.result(mulResult)
	);

endmodule

`default_nettype wire

// File: hdl/fpMultiplier.sv
`timescale 1ns/1ps
`default_nettype none

module fpMultiplier (
	input  logic           clk,
	input  logic           rst,
	input  logic           start,
	input  fpaPkg::fpVal_t a,
	input  fpaPkg::fpVal_t b,
	output logic           done,
	output fpaPkg::fpVal_t result
);

	localparam int ManBits = fpaPkg::ManBits;
	localparam int ExpBits = fpaPkg::ExpBits;
	localparam int CntBits = $clog2(ManBits);

	typedef enum logic [1:0] {
		MIdle,
		MRun,
		MNorm
	} mulState_t;

	mulState_t            state;
	logic [CntBits-1:0]   stepCnt;
	// Upper half accumulates, lower half starts as the multiplier
	logic [2*ManBits-1:0] prod;
	logic [ManBits-1:0]   mcand;
	logic [ManBits:0]     partial;
	logic                 resSign;
	logic [ExpBits-1:0]   resExp;
	logic                 zeroOp;

	assign zeroOp = (a.exponent == '0) || (b.exponent == '0);

	// Add the multiplicand when the current multiplier bit is set
	assign partial = {1'b0, prod[2*ManBits-1:ManBits]} + (prod[0] ? {1'b0, mcand} : '0);

	// ====================
	// Control
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= MIdle;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				MIdle: begin
					if (start) begin
						// Zero operand finishes right away
						if (zeroOp) begin
							done <= 1'b1;
						end else begin
							state <= MRun;
						end
					end
				end
				MRun: begin
					if (stepCnt == CntBits'(ManBits - 1)) begin
						state <= MNorm;
					end
				end
				MNorm: begin
					state <= MIdle;
					done <= 1'b1;
				end
				default: state <= MIdle;
			endcase
		end
	end

	// Datapath
	always_ff @(posedge clk) begin
		case (state)
			MIdle: begin
				if (start) begin
					mcand <= a.mantissa;
					prod <= {{ManBits{1'b0}}, b.mantissa};
					stepCnt <= '0;
					resSign <= a.sign ^ b.sign;
					// Overflow and underflow are out of scope
					resExp <= ExpBits'(int'(a.exponent) + int'(b.exponent) - fpaPkg::ExpBias);
					if (zeroOp) begin
						result <= '0;
					end
				end
			end
			MRun: begin
				// Shift right with the carry out of the add
				prod <= {partial, prod[ManBits-1:1]};
				stepCnt <= stepCnt + 1'b1;
			end
			MNorm: begin
				result.sign <= resSign;
				// Product of two normalized mantissas is in [1,4), one shift at most
				if (prod[2*ManBits-1]) begin
					result.mantissa <= prod[2*ManBits-1:ManBits];
					result.exponent <= resExp + 1'b1;
				end else begin
					result.mantissa <= prod[2*ManBits-2:ManBits-1];
					result.exponent <= resExp;
				end
			end
			default: ;
		endcase
	end

	// Sequencer keeps one multiply in flight at a time
	assert property (@(posedge clk) disable iff (rst) start |-> state == MIdle);

endmodule

`default_nettype wire

// File: hdl/fixToFloat.sv
`timescale 1ns/1ps
`default_nettype none

module fixToFloat (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      start,
	input  logic [fpaPkg::ManBits-1:0] intIn,
	output logic                      done,
	output fpaPkg::fpVal_t            result
);

	localparam int ManBits = fpaPkg::ManBits;
	localparam int ExpBits = fpaPkg::ExpBits;
	// Enough for a shift count up to ManBits-1
	localparam int CntBits = $clog2(ManBits);

	logic               running;
	logic               negative;
	logic [ManBits-1:0] mag;
	logic [CntBits-1:0] shiftCnt;
	logic               normalized;

	// Stop once the leading one sits at the top, or the value is zero
	assign normalized = mag[ManBits-1] || (mag == '0);

	// ====================
	// Control
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start && !running) begin
				running <= 1'b1;
			end else if (running && normalized) begin
				running <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// Datapath
	always_ff @(posedge clk) begin
		if (start && !running) begin
			// Sign and two's-complement magnitude
			negative <= intIn[ManBits-1];
			mag <= intIn[ManBits-1] ? -intIn : intIn;
			shiftCnt <= '0;
		end else if (running && !normalized) begin
			// One bit of left shift per cycle
			mag <= mag << 1;
			shiftCnt <= shiftCnt + 1'b1;
		end
		if (running && normalized) begin
			result.sign <= negative;
			result.mantissa <= mag;
			if (mag == '0) begin
				result.exponent <= '0;
			end else begin
				result.exponent <= ExpBits'(fpaPkg::ExpBias + ManBits - 1 - int'(shiftCnt));
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/fpaSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fpaSequencer (
	input  logic           clk,
	input  logic           rst,
	input  logic           cmdValid,
	input  fpaPkg::fpaOp_t cmdOp,
	input  fpaPkg::fpVal_t fac1,
	input  fpaPkg::fpVal_t fac2,
	input  logic           fixDone,
	input  fpaPkg::fpVal_t fixResult,
	input  logic           mulDone,
	input  fpaPkg::fpVal_t mulResult,
	output logic           busy,
	output logic           fixStart,
	output logic           mulStart,
	output logic           loadFac1,
	output logic           loadFac2,
	output fpaPkg::fpVal_t newFac1,
	output fpaPkg::fpVal_t newFac2
);

	typedef enum logic [1:0] {
		SIdle,
		SSwap,
		SWaitFix,
		SWaitMul
	} seqState_t;

	seqState_t state;
	seqState_t stateNext;
	logic      launch;

	// ====================
	// Command decode
	// ====================

	// A command is only taken when nothing is running
	assign launch = cmdValid && (state == SIdle);
	assign fixStart = launch && (cmdOp == fpaPkg::OpFix2Flt);
	assign mulStart = launch && (cmdOp == fpaPkg::OpMul);

	always_comb begin
		stateNext = state;
		case (state)
			SIdle: begin
				if (cmdValid) begin
					// Unknown opcodes fall through and stay idle
					case (cmdOp)
						fpaPkg::OpSwap:    stateNext = SSwap;
						fpaPkg::OpFix2Flt: stateNext = SWaitFix;
						fpaPkg::OpMul:     stateNext = SWaitMul;
						default:           stateNext = SIdle;
					endcase
				end
			end
			// Exchange takes one cycle
			SSwap: stateNext = SIdle;
			SWaitFix: begin
				if (fixDone) begin
					stateNext = SIdle;
				end
			end
			SWaitMul: begin
				if (mulDone) begin
					stateNext = SIdle;
				end
			end
			default: stateNext = SIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= SIdle;
		end else begin
			state <= stateNext;
		end
	end

	assign busy = (state != SIdle);

	// ====================
	// Write back
	// ====================

	// Loads land on the edge that returns to idle
	assign loadFac1 = (state == SSwap) ||
		((state == SWaitFix) && fixDone) ||
		((state == SWaitMul) && mulDone);
	assign loadFac2 = (state == SSwap);

	always_comb begin
		case (state)
			SSwap:    newFac1 = fac2;
			SWaitMul: newFac1 = mulResult;
			default:  newFac1 = fixResult;
		endcase
	end

	// FAC2 only ever receives the old FAC1 on a swap
	assign newFac2 = fac1;

	// Bus side must hold commands off until the previous one finished
	assert property (@(posedge clk) disable iff (rst) cmdValid |-> !busy);

endmodule

`default_nettype wire

// File: hdl/fpaBusRegs.sv
`timescale 1ns/1ps
`default_nettype none

module fpaBusRegs (
	input  logic            clk,
	input  logic            rst,
	input  fpaPkg::busReq_t req,
	input  logic            inWindow,
	input  logic            busy,
	input  logic            loadFac1,
	input  logic            loadFac2,
	input  fpaPkg::fpVal_t  newFac1,
	input  fpaPkg::fpVal_t  newFac2,
	output logic [7:0]      readData,
	output logic            rdy,
	output logic            cmdValid,
	output fpaPkg::fpaOp_t  cmdOp,
	output fpaPkg::fpVal_t  fac1,
	output fpaPkg::fpVal_t  fac2
);

	// Bytes per accumulator
	localparam int FacBytes = fpaPkg::FloatBits / 8;

	logic       access;
	logic [3:0] byteSel;
	logic       isFac1;
	logic       isFac2;
	logic       isCmd;
	logic       stall;
	logic       wrAccepted;

	// ====================
	// Address decode
	// ====================

	assign access = req.vda & inWindow;
	// Low nibble picks the byte inside an accumulator
	assign byteSel = req.addr[3:0];
	assign isFac1 = (req.addr[7:4] == fpaPkg::RegFac1Base[7:4]) && (byteSel < 4'(FacBytes));
	assign isFac2 = (req.addr[7:4] == fpaPkg::RegFac2Base[7:4]) && (byteSel < 4'(FacBytes));
	assign isCmd = (req.addr == fpaPkg::RegCmd);

	// Writes to the FACs or the command wait while an operation is pending
	// A command still in flight to the sequencer counts as pending too
	assign stall = access & ~req.rw & (isFac1 | isFac2 | isCmd) & (busy | cmdValid);
	assign rdy = ~stall;

	// Write takes place on the edge where the master sees rdy
	assign wrAccepted = access & ~req.rw & rdy;

	// ====================
	// Accumulators
	// ====================

	// Sequencer load wins over a bus byte write
	always_ff @(posedge clk) begin
		if (rst) begin
			fac1 <= '0;
			fac2 <= '0;
		end else begin
			if (loadFac1) begin
				fac1 <= newFac1;
			end else if (wrAccepted && isFac1) begin
				fac1[8*byteSel +: 8] <= req.writeData;
			end
			if (loadFac2) begin
				fac2 <= newFac2;
			end else if (wrAccepted && isFac2) begin
				fac2[8*byteSel +: 8] <= req.writeData;
			end
		end
	end

	// ====================
	// Command register
	// ====================

	// One pulse per accepted command write
	always_ff @(posedge clk) begin
		if (rst) begin
			cmdValid <= 1'b0;
		end else begin
			cmdValid <= wrAccepted && isCmd;
		end
	end

	// Opcode byte is only meaningful alongside cmdValid
	always_ff @(posedge clk) begin
		if (wrAccepted && isCmd) begin
			cmdOp <= fpaPkg::fpaOp_t'(req.writeData);
		end
	end

	// Read mux gives zero for holes and outside the window
	always_comb begin
		readData = 8'h00;
		if (inWindow) begin
			if (isFac1) begin
				readData = fac1[8*byteSel +: 8];
			end else if (isFac2) begin
				readData = fac2[8*byteSel +: 8];
			end else if (isCmd) begin
				// Status with busy in bit 7
				readData = {busy, 7'b0};
			end
		end
	end

	// Sequencer writes back only while an operation runs
	assert property (@(posedge clk) disable iff (rst) (loadFac1 || loadFac2) |-> busy);
	// FAC2 is only loaded by a swap and a swap loads FAC1 too
	assert property (@(posedge clk) disable iff (rst) loadFac2 |-> loadFac1);

endmodule

`default_nettype wire

// File: hdl/fpaPkg.sv
`default_nettype none

package fpaPkg;

	// ====================
	// Number format
	// ====================

	// Triple precision word
	localparam int FloatBits = 96;
	// Mantissa with explicit leading one at the top bit
	localparam int ManBits = 80;
	localparam int ExpBits = 15;
	// Exponent bias, zero exponent means a zero value
	localparam int ExpBias = 16383;

	// Sign, exponent, mantissa, most significant first
	typedef struct packed {
		logic               sign;
		logic [ExpBits-1:0] exponent;
		logic [ManBits-1:0] mantissa;
	} fpVal_t;

	// ====================
	// Bus side
	// ====================

	// Decoded processor access, addr is the offset from the base
	typedef struct packed {
		logic       vda;
		// High for a read
		logic       rw;
		logic [7:0] addr;
		logic [7:0] writeData;
	} busReq_t;

	// Command byte values
	typedef enum logic [7:0] {
		OpFix2Flt = 8'h05,
		OpMul     = 8'h06,
		OpSwap    = 8'h11
	} fpaOp_t;

	// Register offsets
	localparam logic [7:0] RegFac1Base = 8'h00;
	localparam logic [7:0] RegFac2Base = 8'h10;
	// Command on write, status on read
	localparam logic [7:0] RegCmd = 8'h0F;

endpackage

`default_nettype wire
